// ==== rtl/rv_pkg.sv ====
package rv_pkg;

  // data word and register index
  typedef logic [31:0] rv_word_t;
  typedef logic [4:0]  rv_reg_addr_t;

  localparam int NUM_REGS = 32;

  // major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_MISC_MEM = 7'b0001111,
    OPC_JAL      = 7'b1101111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_SYSTEM   = 7'b1110011,
    OPC_AUIPC    = 7'b0010111,
    OPC_LUI      = 7'b0110111
  } rv_opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } rv_alu_op_e;

  // values match funct3 of the M extension
  typedef enum logic [2:0] {
    MD_MUL    = 3'b000,
    MD_MULH   = 3'b001,
    MD_MULHSU = 3'b010,
    MD_MULHU  = 3'b011,
    MD_DIV    = 3'b100,
    MD_DIVU   = 3'b101,
    MD_REM    = 3'b110,
    MD_REMU   = 3'b111
  } rv_md_op_e;

  typedef enum logic [2:0] {
    WB_ALU,
    WB_MULDIV,
    WB_IMM,
    WB_PC_IMM,
    WB_PC4
  } rv_wb_sel_e;

  // funct7 patterns
  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // funct3 for op and op-imm
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 for branches and jalr
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;
  localparam logic [2:0] F3_JALR = 3'b000;

endpackage

// ==== rtl/rv_cla_adder.sv ====
`timescale 1ns/100ps

module rv_cla_adder (
  input  rv_pkg::rv_word_t i_a,
  input  rv_pkg::rv_word_t i_b,
  input  logic             i_cin,
  output rv_pkg::rv_word_t o_sum
);

  import rv_pkg::*;

  rv_word_t   gen;
  rv_word_t   prop;
  rv_word_t   carry;
  logic [7:0] grp_g;
  logic [7:0] grp_p;
  logic [7:0] grp_c;
  logic [1:0] blk_gp;
  logic       blk_cout;

  // {group generate, group propagate} of four bits
  function automatic logic [1:0] gp4(input logic [3:0] g, input logic [3:0] p);
    gp4[1] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);
    gp4[0] = &p;
  endfunction

  // carry into each of four positions, by lookahead from cin
  function automatic logic [3:0] carry4(input logic [3:0] g, input logic [3:0] p,
                                        input logic cin);
    carry4[0] = cin;
    carry4[1] = g[0] | (p[0] & cin);
    carry4[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    carry4[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cin);
  endfunction

  assign gen  = i_a & i_b;
  assign prop = i_a ^ i_b;

  for (genvar k = 0; k < 8; k++) begin : g_group
    assign {grp_g[k], grp_p[k]} = gp4(gen[4*k+3 -: 4], prop[4*k+3 -: 4]);
    assign carry[4*k+3 -: 4] = carry4(gen[4*k+3 -: 4], prop[4*k+3 -: 4], grp_c[k]);
  end

  // second level over groups, split into two blocks of four
  assign grp_c[3:0] = carry4(grp_g[3:0], grp_p[3:0], i_cin);
  assign blk_gp     = gp4(grp_g[3:0], grp_p[3:0]);
  assign blk_cout   = blk_gp[1] | (blk_gp[0] & i_cin);
  assign grp_c[7:4] = carry4(grp_g[7:4], grp_p[7:4], blk_cout);

  assign o_sum = prop ^ carry;

endmodule

// ==== rtl/rv_alu.sv ====
`timescale 1ns/100ps

module rv_alu (
  input  rv_pkg::rv_alu_op_e i_op,
  input  rv_pkg::rv_word_t   i_a,
  input  rv_pkg::rv_word_t   i_b,
  output rv_pkg::rv_word_t   o_result,
  output logic               o_eq,
  output logic               o_lt,
  output logic               o_ltu
);

  import rv_pkg::*;

  logic       sub_mode;
  rv_word_t   b_in;
  rv_word_t   sum;
  logic [4:0] shamt;

  // everything except add runs the adder as a - b
  assign sub_mode = (i_op != ALU_ADD);
  assign b_in     = sub_mode ? ~i_b : i_b;
  assign shamt    = i_b[4:0];

  rv_cla_adder rv_cla_adder_inst (
    .i_a   (i_a),
    .i_b   (b_in),
    .i_cin (sub_mode),
    .o_sum (sum)
  );

  // flags read the difference, valid whenever the adder subtracts
  assign o_eq  = (sum == '0);
  assign o_lt  = (i_a[31] ^ i_b[31]) ? i_a[31] : sum[31];
  assign o_ltu = (i_a[31] ^ i_b[31]) ? i_b[31] : sum[31];

  always_comb begin
    case (i_op)
      ALU_ADD,
      ALU_SUB:  o_result = sum;
      ALU_SLL:  o_result = i_a << shamt;
      ALU_SLT:  o_result = {31'd0, o_lt};
      ALU_SLTU: o_result = {31'd0, o_ltu};
      ALU_XOR:  o_result = i_a ^ i_b;
      ALU_SRL:  o_result = i_a >> shamt;
      ALU_SRA:  o_result = rv_word_t'($signed(i_a) >>> shamt);
      ALU_OR:   o_result = i_a | i_b;
      ALU_AND:  o_result = i_a & i_b;
      default:  o_result = sum;
    endcase
  end

endmodule

// ==== rtl/rv_muldiv.sv ====
`timescale 1ns/100ps

module rv_muldiv (
  input  rv_pkg::rv_md_op_e i_op,
  input  rv_pkg::rv_word_t  i_a,
  input  rv_pkg::rv_word_t  i_b,
  output rv_pkg::rv_word_t  o_result
);

  import rv_pkg::*;

  logic               mul_a_sgn;
  logic               mul_b_sgn;
  logic signed [32:0] mul_a;
  logic signed [32:0] mul_b;
  logic signed [65:0] product;

  logic     div_signed;
  logic     a_neg;
  logic     b_neg;
  logic     div_by_zero;
  logic     q_neg;
  rv_word_t mag_a;
  rv_word_t mag_b;
  rv_word_t quo;
  rv_word_t rem;
  rv_word_t quo_s;
  rv_word_t rem_s;
  rv_word_t part [33];

  // one 33x33 signed multiply, the extra bit carries each operand's sign
  assign mul_a_sgn = (i_op == MD_MULH) || (i_op == MD_MULHSU);
  assign mul_b_sgn = (i_op == MD_MULH);
  assign mul_a     = {mul_a_sgn & i_a[31], i_a};
  assign mul_b     = {mul_b_sgn & i_b[31], i_b};
  assign product   = mul_a * mul_b;

  // divide magnitudes, signs applied afterwards
  assign div_signed  = (i_op == MD_DIV) || (i_op == MD_REM);
  assign a_neg       = div_signed & i_a[31];
  assign b_neg       = div_signed & i_b[31];
  assign mag_a       = a_neg ? -i_a : i_a;
  assign mag_b       = b_neg ? -i_b : i_b;
  assign div_by_zero = (i_b == '0);

  // restoring divider, one quotient bit per stage, msb first
  assign part[0] = '0;
  for (genvar s = 0; s < 32; s++) begin : g_div_stage
    logic [32:0] shifted;
    logic [32:0] trial;
    assign shifted     = {part[s], mag_a[31-s]};
    assign trial       = shifted - {1'b0, mag_b};
    assign quo[31-s]   = ~trial[32];
    assign part[s + 1] = trial[32] ? shifted[31:0] : trial[31:0];
  end
  assign rem = part[32];

  // a zero divisor leaves all ones and the dividend, which must not be negated;
  // min / -1 already gives the dividend and a zero remainder
  assign q_neg = (a_neg ^ b_neg) & ~div_by_zero;
  assign quo_s = q_neg ? -quo : quo;
  assign rem_s = a_neg ? -rem : rem;

  always_comb begin
    case (i_op)
      MD_MUL:    o_result = product[31:0];
      MD_MULH,
      MD_MULHSU,
      MD_MULHU:  o_result = product[63:32];
      MD_DIV,
      MD_DIVU:   o_result = quo_s;
      default:   o_result = rem_s;
    endcase
  end

endmodule

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_we,
  input  rv_pkg::rv_reg_addr_t i_rd,
  input  rv_pkg::rv_word_t     i_rd_data,
  input  rv_pkg::rv_reg_addr_t i_rs1,
  input  rv_pkg::rv_reg_addr_t i_rs2,
  output rv_pkg::rv_word_t     o_rs1_data,
  output rv_pkg::rv_word_t     o_rs2_data
);

  import rv_pkg::*;

  rv_word_t regs [NUM_REGS];

  // asynchronous read ports
  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  // x0 is cleared by reset and never written again
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_rd_data;
    end
  end

endmodule

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/100ps

module rv_decoder (
  input  rv_pkg::rv_word_t     i_insn,
  output rv_pkg::rv_reg_addr_t o_rs1,
  output rv_pkg::rv_reg_addr_t o_rs2,
  output rv_pkg::rv_reg_addr_t o_rd,
  output rv_pkg::rv_word_t     o_imm,
  output rv_pkg::rv_alu_op_e   o_alu_op,
  output logic                 o_alu_use_imm,
  output logic                 o_rd_we,
  output logic                 o_is_branch,
  output logic                 o_is_jal,
  output logic                 o_is_jalr,
  output logic                 o_is_ecall,
  output logic                 o_illegal,
  output logic [2:0]           o_branch_funct,
  output rv_pkg::rv_md_op_e    o_md_op,
  output rv_pkg::rv_wb_sel_e   o_wb_sel
);

  import rv_pkg::*;

  rv_opcode_e opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_word_t   imm_i;
  rv_word_t   imm_s;
  rv_word_t   imm_b;
  rv_word_t   imm_j;
  rv_word_t   imm_u;
  rv_alu_op_e alu_op_dec;
  logic       alu_legal;

  assign opcode = rv_opcode_e'(i_insn[6:0]);
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];

  assign o_rs1 = i_insn[19:15];
  assign o_rs2 = i_insn[24:20];
  assign o_rd  = i_insn[11:7];
  assign o_branch_funct = funct3;
  assign o_md_op = rv_md_op_e'(funct3);

  // immediates, all sign-extended from bit 31
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
  assign imm_u = {i_insn[31:12], 12'h000};

  // funct3/funct7 to ALU op, shared by op and op-imm
  always_comb begin
    alu_legal = 1'b1;
    case (funct3)
      F3_ADD:  alu_op_dec = (opcode == OPC_OP && funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
      F3_SLL:  alu_op_dec = ALU_SLL;
      F3_SLT:  alu_op_dec = ALU_SLT;
      F3_SLTU: alu_op_dec = ALU_SLTU;
      F3_XOR:  alu_op_dec = ALU_XOR;
      F3_SRL:  alu_op_dec = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
      F3_OR:   alu_op_dec = ALU_OR;
      default: alu_op_dec = ALU_AND;
    endcase
    // op-imm only carries a funct7 on the shifts
    if (opcode == OPC_OP || funct3 == F3_SLL || funct3 == F3_SRL) begin
      case (funct7)
        FUNCT7_BASE: alu_legal = 1'b1;
        FUNCT7_ALT:  alu_legal = (funct3 == F3_SRL) || (funct3 == F3_ADD && opcode == OPC_OP);
        default:     alu_legal = 1'b0;
      endcase
    end
  end

  always_comb begin
    o_imm         = imm_i;
    o_alu_op      = ALU_ADD;
    o_alu_use_imm = 1'b0;
    o_rd_we       = 1'b0;
    o_is_branch   = 1'b0;
    o_is_jal      = 1'b0;
    o_is_jalr     = 1'b0;
    o_is_ecall    = 1'b0;
    o_illegal     = 1'b0;
    o_wb_sel      = WB_ALU;
    case (opcode)
      OPC_OP_IMM: begin
        o_alu_op      = alu_op_dec;
        o_alu_use_imm = 1'b1;
        o_rd_we       = 1'b1;
        o_illegal     = !alu_legal;
      end
      OPC_OP: begin
        o_rd_we = 1'b1;
        if (funct7 == FUNCT7_MULDIV) begin
          o_wb_sel = WB_MULDIV;
        end else begin
          o_alu_op  = alu_op_dec;
          o_illegal = !alu_legal;
        end
      end
      OPC_BRANCH: begin
        // subtract so the ALU compare flags are valid
        o_imm       = imm_b;
        o_alu_op    = ALU_SUB;
        o_illegal   = (funct3[2:1] == 2'b01);
        o_is_branch = !o_illegal;
      end
      OPC_JAL: begin
        o_imm    = imm_j;
        o_is_jal = 1'b1;
        o_rd_we  = 1'b1;
        o_wb_sel = WB_PC4;
      end
      OPC_JALR: begin
        // target is rs1 + imm from the ALU
        o_alu_use_imm = 1'b1;
        o_rd_we       = 1'b1;
        o_wb_sel      = WB_PC4;
        o_is_jalr     = (funct3 == F3_JALR);
        o_illegal     = !o_is_jalr;
      end
      OPC_LUI: begin
        o_imm    = imm_u;
        o_rd_we  = 1'b1;
        o_wb_sel = WB_IMM;
      end
      OPC_AUIPC: begin
        o_imm    = imm_u;
        o_rd_we  = 1'b1;
        o_wb_sel = WB_PC_IMM;
      end
      OPC_SYSTEM: begin
        o_is_ecall = (i_insn[31:7] == 25'd0);
        o_illegal  = !o_is_ecall;
      end
      OPC_STORE: begin
        // no data memory, so stores are reported and skipped
        o_imm     = imm_s;
        o_illegal = 1'b1;
      end
      default: begin
        o_illegal = 1'b1;
      end
    endcase
    if (o_illegal) begin
      o_rd_we = 1'b0;
    end
  end

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/100ps

module rv_core #(
  parameter rv_pkg::rv_word_t RESET_PC = 32'h0000_0000
) (
  input  logic                 clk,
  input  logic                 rst,
  output rv_pkg::rv_word_t     o_imem_addr,
  input  rv_pkg::rv_word_t     i_imem_data,
  output logic                 o_rd_we,
  output rv_pkg::rv_reg_addr_t o_rd_addr,
  output rv_pkg::rv_word_t     o_rd_data,
  output logic                 o_halt,
  output logic                 o_illegal
);

  import rv_pkg::*;

  rv_word_t     pc;
  rv_word_t     next_pc;
  rv_word_t     pc_plus4;
  rv_word_t     pc_plus_imm;
  logic         halted;

  rv_reg_addr_t rs1;
  rv_reg_addr_t rs2;
  rv_reg_addr_t rd;
  rv_word_t     imm;
  rv_alu_op_e   alu_op;
  logic         alu_use_imm;
  logic         dec_rd_we;
  logic         is_branch;
  logic         is_jal;
  logic         is_jalr;
  logic         is_ecall;
  logic         dec_illegal;
  logic [2:0]   branch_funct;
  rv_md_op_e    md_op;
  rv_wb_sel_e   wb_sel;

  rv_word_t     rs1_data;
  rv_word_t     rs2_data;
  rv_word_t     alu_b;
  rv_word_t     alu_result;
  rv_word_t     md_result;
  rv_word_t     wb_data;
  logic         cmp_eq;
  logic         cmp_lt;
  logic         cmp_ltu;
  logic         taken;

  rv_decoder rv_decoder_inst (
    .i_insn         (i_imem_data),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (rd),
    .o_imm          (imm),
    .o_alu_op       (alu_op),
    .o_alu_use_imm  (alu_use_imm),
    .o_rd_we        (dec_rd_we),
    .o_is_branch    (is_branch),
    .o_is_jal       (is_jal),
    .o_is_jalr      (is_jalr),
    .o_is_ecall     (is_ecall),
    .o_illegal      (dec_illegal),
    .o_branch_funct (branch_funct),
    .o_md_op        (md_op),
    .o_wb_sel       (wb_sel)
  );

  rv_regfile rv_regfile_inst (
    .clk        (clk),
    .rst        (rst),
    .i_we       (o_rd_we),
    .i_rd       (rd),
    .i_rd_data  (wb_data),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  assign alu_b = alu_use_imm ? imm : rs2_data;

  rv_alu rv_alu_inst (
    .i_op     (alu_op),
    .i_a      (rs1_data),
    .i_b      (alu_b),
    .o_result (alu_result),
    .o_eq     (cmp_eq),
    .o_lt     (cmp_lt),
    .o_ltu    (cmp_ltu)
  );

  rv_muldiv rv_muldiv_inst (
    .i_op     (md_op),
    .i_a      (rs1_data),
    .i_b      (rs2_data),
    .o_result (md_result)
  );

  assign pc_plus4    = pc + 32'd4;
  assign pc_plus_imm = pc + imm;

  always_comb begin
    case (branch_funct)
      F3_BEQ:  taken = cmp_eq;
      F3_BNE:  taken = !cmp_eq;
      F3_BLT:  taken = cmp_lt;
      F3_BGE:  taken = !cmp_lt;
      F3_BLTU: taken = cmp_ltu;
      F3_BGEU: taken = !cmp_ltu;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (is_jalr) begin
      next_pc = {alu_result[31:1], 1'b0};
    end else if (is_jal || (is_branch && taken)) begin
      next_pc = pc_plus_imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_comb begin
    case (wb_sel)
      WB_MULDIV: wb_data = md_result;
      WB_IMM:    wb_data = imm;
      WB_PC_IMM: wb_data = pc_plus_imm;
      WB_PC4:    wb_data = pc_plus4;
      default:   wb_data = alu_result;
    endcase
  end

  // pc holds on the ecall itself, so the halt address is the ecall's
  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else if (!halted) begin
      if (is_ecall) begin
        halted <= 1'b1;
      end else begin
        pc <= next_pc;
      end
    end
  end

  assign o_imem_addr = pc;
  assign o_halt      = halted;
  // nothing retires and nothing is flagged while reset is applied
  assign o_rd_we     = dec_rd_we && !halted && !rst && (rd != '0);
  assign o_illegal   = dec_illegal && !rst;
  assign o_rd_addr   = rd;
  assign o_rd_data   = wb_data;

endmodule

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/100ps

module rv_core_tb;

  import rv_pkg::*;

  localparam rv_word_t RESET_PC     = 32'h0000_0000;
  localparam int       IMEM_WORDS   = 256;
  localparam int       HALT_TIMEOUT = 2000;
  localparam int       HALT_WATCH   = 16;
  localparam rv_word_t ECALL_INSN   = 32'h0000_0073;
  localparam string    TRACE_FILE   = "sim/rv_core_trace.txt";

  logic         clk;
  logic         rst;
  rv_word_t     imem_addr;
  rv_word_t     imem_data;
  logic         rd_we;
  rv_reg_addr_t rd_addr;
  rv_word_t     rd_data;
  logic         halt;
  logic         illegal;

  // program memory, filled from P records
  rv_word_t               imem [IMEM_WORDS];
  logic [IMEM_WORDS-1:0]  imem_loaded;
  logic [7:0]             imem_idx;
  logic                   fetch_ok;

  // expected retire sequence from W records
  rv_reg_addr_t exp_reg_q [$];
  rv_word_t     exp_data_q [$];
  rv_word_t     exp_halt_addr;

  int   pass_count;
  int   fail_count;
  int   test_errors;
  int   retire_count;
  int   illegal_cycles;
  logic timed_out;

  rv_core #(
    .RESET_PC (RESET_PC)
  ) rv_core_inst (
    .clk         (clk),
    .rst         (rst),
    .o_imem_addr (imem_addr),
    .i_imem_data (imem_data),
    .o_rd_we     (rd_we),
    .o_rd_addr   (rd_addr),
    .o_rd_data   (rd_data),
    .o_halt      (halt),
    .o_illegal   (illegal)
  );

  // combinational fetch, anything outside the program reads as ecall
  assign imem_idx  = imem_addr[9:2];
  assign fetch_ok  = (imem_addr[31:10] == '0) && (imem_addr[1:0] == 2'b00) &&
                     imem_loaded[imem_idx];
  assign imem_data = fetch_ok ? imem[imem_idx] : ECALL_INSN;

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic check_word(input string name, input rv_word_t got, input rv_word_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %08h, expected %08h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_reg(input string name, input rv_reg_addr_t got,
                           input rv_reg_addr_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %02h, expected %02h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s = %01h, expected %01h", name, got, exp);
      test_errors++;
    end
  endtask

  // closes the current test and prints its result line
  task automatic end_test(input string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("[pass] %s", name);
    end else begin
      fail_count++;
      $display("[fail] %s", name);
    end
    test_errors = 0;
  endtask

  task automatic load_trace();
    int               fd;
    int               code;
    logic             done;
    logic [7:0]       kind;
    logic [31:0]      val_a;
    logic [31:0]      val_b;
    logic [8*160-1:0] rest;
    imem_loaded = '0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("could not open %s", TRACE_FILE);
      test_errors++;
      end_test("trace file");
      return;
    end
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) begin
        done = 1'b1;
      end else begin
        case (kind)
          "#": code = $fgets(rest, fd);
          "P": begin
            code = $fscanf(fd, "%h %h", val_a, val_b);
            imem[val_a[9:2]]        = val_b;
            imem_loaded[val_a[9:2]] = 1'b1;
          end
          "W": begin
            code = $fscanf(fd, "%h %h", val_a, val_b);
            exp_reg_q.push_back(val_a[4:0]);
            exp_data_q.push_back(val_b);
          end
          "H": code = $fscanf(fd, "%h", exp_halt_addr);
          default: begin
            $display("trace file holds an unknown record type '%c'", kind);
            test_errors++;
            done = 1'b1;
          end
        endcase
      end
    end
    $fclose(fd);
    end_test($sformatf("trace loaded, %0d retire records", exp_reg_q.size()));
  endtask

  task automatic check_retire();
    rv_reg_addr_t exp_reg;
    rv_word_t     exp_val;
    retire_count++;
    if (exp_reg_q.size() == 0) begin
      $display("register write to x%0d that the trace does not expect", rd_addr);
      test_errors++;
    end else begin
      exp_reg = exp_reg_q.pop_front();
      exp_val = exp_data_q.pop_front();
      check_reg("o_rd_addr", rd_addr, exp_reg);
      check_word("o_rd_data", rd_data, exp_val);
    end
    end_test($sformatf("retire %0d at pc %08h", retire_count, imem_addr));
  endtask

  // samples at the falling edge, where the current instruction is settled
  task automatic wait_for_halt(output logic expired);
    int cycles;
    expired = 1'b1;
    cycles  = 0;
    while (expired && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (halt) begin
        expired = 1'b0;
      end else begin
        if (illegal) begin
          illegal_cycles++;
        end
        if (rd_we) begin
          check_retire();
        end
      end
    end
  endtask

  task automatic check_halted_state();
    check_word("o_imem_addr", imem_addr, exp_halt_addr);
    end_test("halt address");
    if (exp_reg_q.size() != 0) begin
      $display("%0d expected register writes never happened", exp_reg_q.size());
      test_errors++;
    end
    if (illegal_cycles != 0) begin
      $display("o_illegal was high in %0d cycles of the program", illegal_cycles);
      test_errors++;
    end
    end_test("all retire records seen, no illegal instructions");
    repeat (HALT_WATCH) begin
      @(negedge clk);
      check_word("o_imem_addr", imem_addr, exp_halt_addr);
      check_flag("o_halt", halt, 1'b1);
      check_flag("o_rd_we", rd_we, 1'b0);
    end
    end_test("halted core holds its pc and writes nothing");
  endtask

  initial begin
    rst            = 1'b1;
    pass_count     = 0;
    fail_count     = 0;
    test_errors    = 0;
    retire_count   = 0;
    illegal_cycles = 0;
    exp_halt_addr  = '0;
    load_trace();

    // reset for 8 cycles, state checked while it is still applied
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_word("o_imem_addr", imem_addr, RESET_PC);
    check_flag("o_halt", halt, 1'b0);
    check_flag("o_rd_we", rd_we, 1'b0);
    check_flag("o_illegal", illegal, 1'b0);
    end_test("reset state");
    @(posedge clk);
    rst <= 1'b0;

    wait_for_halt(timed_out);
    if (timed_out) begin
      $display("o_halt did not rise within %0d cycles", HALT_TIMEOUT);
      fail_count++;
    end else begin
      check_halted_state();
    end

    $display("passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/rv_core_trace.txt ====
# P <byte address> <instruction word> | W <register index> <value> | H <halt address>
# all values hex, W records in retire order, text after # is ignored
P 00000000 ff900093 # addi x1, x0, -7
W 01 fffffff9
P 00000004 00300113 # addi x2, x0, 3
W 02 00000003
P 00000008 401101b3 # sub x3, x2, x1
W 03 0000000a
P 0000000c 4010d213 # srai x4, x1, 1
W 04 fffffffc
P 00000010 0020d2b3 # srl x5, x1, x2
W 05 1fffffff
P 00000014 0020a333 # slt x6, x1, x2
W 06 00000001
P 00000018 0020b3b3 # sltu x7, x1, x2
W 07 00000000
P 0000001c 0f00c413 # xori x8, x1, 0xf0
W 08 ffffff09
P 00000020 00411493 # slli x9, x2, 4
W 09 00000030
P 00000024 02208533 # mul x10, x1, x2
W 0a ffffffeb
P 00000028 022095b3 # mulh x11, x1, x2
W 0b ffffffff
P 0000002c 02112633 # mulhsu x12, x2, x1
W 0c 00000002
P 00000030 0210b6b3 # mulhu x13, x1, x1
W 0d fffffff2
P 00000034 0220c733 # div x14, x1, x2
W 0e fffffffe
P 00000038 0220e7b3 # rem x15, x1, x2
W 0f ffffffff
P 0000003c 0220d833 # divu x16, x1, x2
W 10 55555553
P 00000040 0290f8b3 # remu x17, x1, x9
W 11 00000009
P 00000044 0200c933 # div x18, x1, x0 (divide by zero)
W 12 ffffffff
P 00000048 0200e9b3 # rem x19, x1, x0 (divide by zero)
W 13 fffffff9
P 0000004c 80000a37 # lui x20, 0x80000
W 14 80000000
P 00000050 fff00a93 # addi x21, x0, -1
W 15 ffffffff
P 00000054 035a4b33 # div x22, x20, x21 (overflow)
W 16 80000000
P 00000058 035a6bb3 # rem x23, x20, x21 (overflow)
W 17 00000000
P 0000005c 00001c17 # auipc x24, 0x1
W 18 0000105c
P 00000060 00500013 # addi x0, x0, 5 (no retire)
P 00000064 00200cb3 # add x25, x0, x2
W 19 00000003
P 00000068 00210463 # beq x2, x2, +8 (taken)
P 0000006c 001d0d13 # addi x26, x26, 1 (skipped)
P 00000070 00211463 # bne x2, x2, +8 (not taken)
P 00000074 001d0d13 # addi x26, x26, 1
W 1a 00000001
P 00000078 0020c463 # blt x1, x2, +8 (taken)
P 0000007c 001d0d13 # addi x26, x26, 1 (skipped)
P 00000080 0020d463 # bge x1, x2, +8 (not taken)
P 00000084 001d0d13 # addi x26, x26, 1
W 1a 00000002
P 00000088 0020e463 # bltu x1, x2, +8 (not taken)
P 0000008c 001d0d13 # addi x26, x26, 1
W 1a 00000003
P 00000090 0020f463 # bgeu x1, x2, +8 (taken)
P 00000094 001d0d13 # addi x26, x26, 1 (skipped)
P 00000098 00800def # jal x27, +8
W 1b 0000009c
P 0000009c 001d0d13 # addi x26, x26, 1 (skipped)
P 000000a0 0ab00e93 # addi x29, x0, 0xab
W 1d 000000ab
P 000000a4 001e8e67 # jalr x28, 1(x29), target 0xac after bit 0 is cleared
W 1c 000000a8
P 000000a8 001d0d13 # addi x26, x26, 1 (skipped)
P 000000ac 00000073 # ecall
H 000000ac

// ==== all.f ====
rtl/rv_pkg.sv
rtl/rv_cla_adder.sv
rtl/rv_alu.sv
rtl/rv_muldiv.sv
rtl/rv_regfile.sv
rtl/rv_decoder.sv
rtl/rv_core.sv
sim/rv_core_tb.sv
